/* verilog/lsu_pkg.sv */
package lsu_pkg;

    // basic widths of the load path
    localparam int XLEN    = 64;
    localparam int ID_W    = 4;
    localparam int F3_W    = 3;

    // register or data value
    typedef logic [XLEN-1:0] xlen_t;

    // byte address on the read bus
    typedef logic [XLEN-1:0] addr_t;

    // transaction tag on the read bus
    typedef logic [ID_W-1:0] bus_id_t;

    // load width and sign code, RISC-V encoding
    typedef logic [F3_W-1:0] funct3_t;

    // signed loads
    localparam funct3_t F3_LB  = 3'd0;
    localparam funct3_t F3_LH  = 3'd1;
    localparam funct3_t F3_LW  = 3'd2;
    localparam funct3_t F3_LD  = 3'd3;

    // unsigned loads
    localparam funct3_t F3_LBU = 3'd4;
    localparam funct3_t F3_LHU = 3'd5;
    localparam funct3_t F3_LWU = 3'd6;

    // no load uses this code, the stage treats it as a non-load
    localparam funct3_t F3_ILLEGAL = 3'd7;

    // accepted load request, from decode to sequencer and aligner
    typedef struct packed {
        logic    is_load;
        funct3_t funct3;
        addr_t   addr;
    } load_req_t;

    // one read-data beat on the bus
    typedef struct packed {
        bus_id_t id;
        xlen_t   data;
    } bus_rd_resp_t;

    // sequencer states
    //   IDLE  nothing outstanding
    //   ADDR  address offered, waiting for ar_ready
    //   WAIT  address taken, waiting for our beat
    //   DONE  result cycle, write-back strobe
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        WAIT,
        DONE
    } load_state_e;

endpackage

/* verilog/load_req_decode.sv */
`timescale 1ns/1ps

module load_req_decode
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // pipeline request
    input  logic      req_valid,
    input  logic      is_load,
    input  funct3_t   funct3,
    input  xlen_t     base,
    input  xlen_t     offset,

    // sequencer has a load in flight
    input  logic      busy,

    output load_req_t req,
    output logic      start
);

    logic  load_ok;
    logic  accept;
    addr_t eff_addr;

    // funct3 7 is no load at all
    assign load_ok = is_load && (funct3 != F3_ILLEGAL);

    assign accept = req_valid && load_ok && !busy;

    // effective address, base plus sign-extended offset from execute
    assign eff_addr = base + offset;

    // request is held until the next accepted load
    always_ff @(posedge clk) begin
        if (accept) begin
            req.is_load <= 1'b1;
            req.funct3  <= funct3;
            req.addr    <= eff_addr;
        end
    end

    // accept strobe, the sequencer moves to ADDR on this edge
    // req carries the latched values from the next cycle on
    assign start = accept;

    // upstream stalls behind the load, so no new request while busy
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(req_valid && busy)
    ) else $error("req_valid while the sequencer is busy");

endmodule

/* verilog/load_bus_fsm.sv */
`timescale 1ns/1ps

module load_bus_fsm
    import lsu_pkg::*;
#(
    parameter bus_id_t LOAD_ID = 4'd2
) (
    input  logic         clk,
    input  logic         rst_n,

    // from decode
    input  logic         start,
    input  addr_t        addr,

    // read address channel
    output logic         ar_valid,
    input  logic         ar_ready,
    output addr_t        ar_addr,
    output bus_id_t      ar_id,

    // read data channel has no ready
    input  logic         r_valid,
    input  bus_rd_resp_t r_beat,

    output logic         busy,
    output logic         done,
    output xlen_t        rdata
);

    load_state_e state_q;
    load_state_e state_d;
    logic        beat_ours;

    // beats for other masters share the channel
    assign beat_ours = r_valid && (r_beat.id == LOAD_ID);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = ADDR;
                end
            end
            ADDR: begin
                if (ar_ready) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (beat_ours) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // captures the first matching beat only
    always_ff @(posedge clk) begin
        if (state_q == WAIT && beat_ours) begin
            rdata <= r_beat.data;
        end
    end

    // addr is the latched request and holds through ADDR
    assign ar_valid = (state_q == ADDR);
    assign ar_addr  = addr;
    assign ar_id    = LOAD_ID;

    assign busy = (state_q == ADDR) || (state_q == WAIT);
    assign done = (state_q == DONE);

    // address channel must not change under back-pressure
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ar_valid && !ar_ready) |=> $stable(ar_addr)
    ) else $error("ar_addr changed before ar_ready");

    // write-back strobe is a single pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("done held for more than one cycle");

endmodule

/* verilog/load_data_align.sv */
`timescale 1ns/1ps

module load_data_align
    import lsu_pkg::*;
(
    input  load_req_t req,
    input  xlen_t     rdata,
    input  logic      done,
    input  xlen_t     ex_result,
    input  logic      is_load,
    output xlen_t     wb_data
);

    logic [5:0] shamt;
    xlen_t      shifted;
    xlen_t      aligned;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;
    logic        use_load;

    // byte offset inside the doubleword, in bits
    assign shamt   = {req.addr[2:0], 3'b000};
    assign shifted = rdata >> shamt;

    assign lane_b = shifted[7:0];
    assign lane_h = shifted[15:0];
    assign lane_w = shifted[31:0];

    always_comb begin
        case (req.funct3)
            F3_LB: begin
                aligned = {{56{lane_b[7]}}, lane_b};
            end
            F3_LH: begin
                aligned = {{48{lane_h[15]}}, lane_h};
            end
            F3_LW: begin
                aligned = {{32{lane_w[31]}}, lane_w};
            end
            F3_LBU: begin
                aligned = {56'd0, lane_b};
            end
            F3_LHU: begin
                aligned = {48'd0, lane_h};
            end
            F3_LWU: begin
                aligned = {32'd0, lane_w};
            end
            // LD takes the whole doubleword, offset is zero
            default: begin
                aligned = shifted;
            end
        endcase
    end

    // load result only in the done cycle, execute value otherwise
    assign use_load = done && is_load;
    assign wb_data  = use_load ? aligned : ex_result;

    // misaligned accesses trap before this stage, none should reach it
    always_comb begin
        if (use_load) begin
            case (req.funct3)
                F3_LH, F3_LHU: begin
                    a_half_aligned: assert (req.addr[0] == 1'b0)
                        else $error("halfword load not aligned");
                end
                F3_LW, F3_LWU: begin
                    a_word_aligned: assert (req.addr[1:0] == 2'b00)
                        else $error("word load not aligned");
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
    import lsu_pkg::*;
#(
    parameter bus_id_t LOAD_ID = 4'd2
) (
    input  logic         clk,
    input  logic         rst_n,

    // from execute
    input  logic         req_valid,
    input  logic         is_load,
    input  funct3_t      funct3,
    input  xlen_t        base,
    input  xlen_t        offset,
    input  xlen_t        ex_result,

    // to write-back and hazard logic
    output xlen_t        wb_data,
    output logic         wb_valid,
    output logic         stall,

    // read address channel
    output logic         ar_valid,
    input  logic         ar_ready,
    output addr_t        ar_addr,
    output bus_id_t      ar_id,

    // read data channel
    input  logic         r_valid,
    input  bus_rd_resp_t r_beat
);

    load_req_t req;
    logic      start;
    logic      busy;
    logic      done;
    xlen_t     rdata;

    load_req_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .is_load   (is_load),
        .funct3    (funct3),
        .base      (base),
        .offset    (offset),
        .busy      (busy),
        .req       (req),
        .start     (start)
    );

    load_bus_fsm #(
        .LOAD_ID (LOAD_ID)
    ) u_bus_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .addr     (req.addr),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_id    (ar_id),
        .r_valid  (r_valid),
        .r_beat   (r_beat),
        .busy     (busy),
        .done     (done),
        .rdata    (rdata)
    );

    // latched request marks the done cycle as a load result
    load_data_align u_align (
        .req       (req),
        .rdata     (rdata),
        .done      (done),
        .ex_result (ex_result),
        .is_load   (req.is_load),
        .wb_data   (wb_data)
    );

    assign wb_valid = done;
    assign stall    = busy;

endmodule

/* verif/tb_bus_responder.sv */
`timescale 1ns/1ps

module tb_bus_responder
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // read address channel
    input  logic         ar_valid,
    output logic         ar_ready,
    input  addr_t        ar_addr,
    input  bus_id_t      ar_id,

    // read data channel
    output logic         r_valid,
    output bus_rd_resp_t r_beat
);

    // doubleword memory, indexed by address bits 12 to 3
    xlen_t mem [0:1023];

    // bus outputs change shortly after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        int      delay;
        int      lat;
        bus_id_t id_q;
        addr_t   addr_q;
        bus_id_t foreign;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_beat   = '0;
        @(posedge rst_n);
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {$urandom, $urandom};
        end
        forever begin
            next_cycle();
            if (ar_valid === 1'b1) begin
                // address ready after 0 to 3 cycles
                delay = int'($urandom_range(3, 0));
                repeat (delay) next_cycle();
                ar_ready = 1'b1;
                id_q     = ar_id;
                addr_q   = ar_addr;
                next_cycle();
                ar_ready = 1'b0;
                // response 1 to 6 cycles after the transfer
                lat = int'($urandom_range(6, 1));
                repeat (lat - 1) next_cycle();
                // beat for another master, same channel
                if ($urandom_range(2, 0) == 0) begin
                    foreign = bus_id_t'($urandom_range(15, 0));
                    if (foreign == id_q) begin
                        foreign = id_q + 4'd1;
                    end
                    r_valid     = 1'b1;
                    r_beat.id   = foreign;
                    r_beat.data = {$urandom, $urandom};
                    next_cycle();
                end
                r_valid     = 1'b1;
                r_beat.id   = id_q;
                r_beat.data = mem[addr_q[12:3]];
                next_cycle();
                r_valid = 1'b0;
                r_beat  = '0;
            end
        end
    end

endmodule

/* verif/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage
    import lsu_pkg::*;
();

    localparam bus_id_t LOAD_ID    = 4'd2;
    localparam int      AR_TIMEOUT = 16;
    localparam int      WB_TIMEOUT = 32;
    localparam int      RANDOM_OPS = 300;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    logic         is_load;
    funct3_t      funct3;
    xlen_t        base;
    xlen_t        offset;
    xlen_t        ex_result;
    xlen_t        wb_data;
    logic         wb_valid;
    logic         stall;
    logic         ar_valid;
    logic         ar_ready;
    addr_t        ar_addr;
    bus_id_t      ar_id;
    logic         r_valid;
    bus_rd_resp_t r_beat;

    int errors;
    int timeouts;
    int loads_done;
    int nonloads_done;

    mem_stage #(
        .LOAD_ID (LOAD_ID)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .is_load   (is_load),
        .funct3    (funct3),
        .base      (base),
        .offset    (offset),
        .ex_result (ex_result),
        .wb_data   (wb_data),
        .wb_valid  (wb_valid),
        .stall     (stall),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .ar_id     (ar_id),
        .r_valid   (r_valid),
        .r_beat    (r_beat)
    );

    tb_bus_responder u_resp (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_id    (ar_id),
        .r_valid  (r_valid),
        .r_beat   (r_beat)
    );

    always #5 clk = ~clk;

    task automatic check_data(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_id(input string what, input bus_id_t got, input bus_id_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // byte offsets a load of this width may use
    function automatic logic [2:0] offset_mask(funct3_t f3);
        logic [2:0] m;
        case (f3)
            F3_LH, F3_LHU: m = 3'b110;
            F3_LW, F3_LWU: m = 3'b100;
            F3_LD:         m = 3'b000;
            default:       m = 3'b111;
        endcase
        return m;
    endfunction

    // picks bytes upward from the address, then extends by sign or zero
    function automatic xlen_t load_model(funct3_t f3, addr_t a, xlen_t dw);
        int         nbytes;
        logic       sext;
        logic [2:0] k;
        logic [2:0] lane;
        logic [5:0] top;
        xlen_t      v;
        case (f3)
            F3_LB, F3_LBU: nbytes = 1;
            F3_LH, F3_LHU: nbytes = 2;
            F3_LW, F3_LWU: nbytes = 4;
            default:       nbytes = 8;
        endcase
        sext = (f3 == F3_LB) || (f3 == F3_LH) || (f3 == F3_LW);
        v = '0;
        for (int n = 0; n < nbytes; n++) begin
            k    = 3'(n);
            lane = a[2:0] + k;
            v[{k, 3'b000} +: 8] = dw[{lane, 3'b000} +: 8];
        end
        top = 6'(8 * nbytes - 1);
        if (sext && v[top]) begin
            for (int n = nbytes; n < 8; n++) begin
                k = 3'(n);
                v[{k, 3'b000} +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic do_load(input funct3_t f3, input logic [2:0] byte_off);
        addr_t a;
        xlen_t exr;
        xlen_t expected;
        int    cycles;
        logic  taken;
        string tag;
        a        = {$urandom, $urandom};
        a[2:0]   = byte_off;
        expected = load_model(f3, a, u_resp.mem[a[12:3]]);
        exr      = {$urandom, $urandom};
        tag      = $sformatf("load f3=%0d addr=%h", f3, a);
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        is_load   = 1'b1;
        funct3    = f3;
        base      = {$urandom, $urandom};
        offset    = a - base;
        ex_result = exr;
        @(negedge clk);
        check_data("wb_data before accept", wb_data, exr);
        check_flag("stall before accept", stall, 1'b0);
        @(posedge clk);
        #1;
        // new operands must not disturb the latched request
        req_valid = 1'b0;
        base      = {$urandom, $urandom};
        offset    = {$urandom, $urandom};
        ex_result = {$urandom, $urandom};
        @(negedge clk);
        cycles = 0;
        do begin
            check_flag("ar_valid in address phase", ar_valid, 1'b1);
            check_flag("stall in address phase", stall, 1'b1);
            check_addr("ar_addr", ar_addr, a);
            check_id("ar_id", ar_id, LOAD_ID);
            taken = (ar_ready === 1'b1);
            if (!taken) begin
                @(negedge clk);
                cycles++;
            end
        end while (!taken && cycles < AR_TIMEOUT);
        if (!taken) begin
            $display("timeout at %0t: no address handshake for %s", $time, tag);
            timeouts++;
            return;
        end
        @(negedge clk);
        cycles = 0;
        while (wb_valid !== 1'b1 && cycles < WB_TIMEOUT) begin
            check_flag("ar_valid while waiting", ar_valid, 1'b0);
            check_flag("stall while waiting", stall, 1'b1);
            check_data("wb_data while waiting", wb_data, ex_result);
            @(negedge clk);
            cycles++;
        end
        if (wb_valid !== 1'b1) begin
            $display("timeout at %0t: no write-back pulse for %s", $time, tag);
            timeouts++;
            return;
        end
        check_data(tag, wb_data, expected);
        check_flag("stall in write-back cycle", stall, 1'b0);
        loads_done++;
        @(negedge clk);
        check_flag("wb_valid after pulse", wb_valid, 1'b0);
        check_flag("stall after load", stall, 1'b0);
    endtask

    // non-load or funct3 7, execute value passes straight through
    task automatic do_nonload();
        xlen_t exr;
        exr = {$urandom, $urandom};
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        if ($urandom_range(3, 0) == 0) begin
            is_load = 1'b1;
            funct3  = F3_ILLEGAL;
        end else begin
            is_load = 1'b0;
            funct3  = funct3_t'($urandom_range(7, 0));
        end
        base      = {$urandom, $urandom};
        offset    = {$urandom, $urandom};
        ex_result = exr;
        @(negedge clk);
        check_data("non-load wb_data", wb_data, exr);
        check_flag("wb_valid on non-load", wb_valid, 1'b0);
        check_flag("stall on non-load", stall, 1'b0);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        ex_result = {$urandom, $urandom};
        @(negedge clk);
        check_flag("ar_valid after non-load", ar_valid, 1'b0);
        check_flag("stall after non-load", stall, 1'b0);
        check_data("wb_data after non-load", wb_data, ex_result);
        nonloads_done++;
    endtask

    initial begin
        funct3_t    f3;
        logic [2:0] off;
        int         i;
        void'($urandom(32'h7f45_c730));
        errors        = 0;
        timeouts      = 0;
        loads_done    = 0;
        nonloads_done = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        is_load   = 1'b0;
        funct3    = '0;
        base      = '0;
        offset    = '0;
        ex_result = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("ar_valid after reset", ar_valid, 1'b0);
        check_flag("wb_valid after reset", wb_valid, 1'b0);
        check_flag("stall after reset", stall, 1'b0);

        // every load code at every legal offset
        for (int n = 0; n < 7; n++) begin
            for (int k = 0; k < 8; k++) begin
                f3  = funct3_t'(n);
                off = 3'(k);
                if ((off & offset_mask(f3)) == off && timeouts == 0) begin
                    do_load(f3, off);
                end
            end
        end

        for (i = 0; i < RANDOM_OPS && timeouts == 0; i++) begin
            if ($urandom_range(9, 0) < 6) begin
                f3  = funct3_t'($urandom_range(6, 0));
                off = 3'($urandom_range(7, 0));
                do_load(f3, off & offset_mask(f3));
            end else begin
                do_nonload();
            end
        end

        $display("loads %0d, non-loads %0d, errors %0d, timeouts %0d",
                 loads_done, nonloads_done, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/lsu_pkg.sv
verilog/load_req_decode.sv
verilog/load_bus_fsm.sv
verilog/load_data_align.sv
verilog/mem_stage.sv
verif/tb_bus_responder.sv
verif/tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_mem_stage
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
